// File: files.f
hdl/uiq_pkg.sv
hdl/uiq_ifs.sv
hdl/op_decoder.sv
hdl/issue_ctrl.sv
hdl/issue_entries.sv
hdl/issue_select.sv
hdl/issue_queue_top.sv
test/tb_issue_queue.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_issue_queue -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

// File: test/tb_issue_queue.sv
module tb_issue_queue;

    localparam int n_random = 400;
    localparam int n_total = n_random + uiq_pkg::depth;
    localparam int n_rob = 1 << uiq_pkg::tag_w;
    localparam int drain_limit = 4 * n_rob;

    logic clk;
    logic rstn;
    logic disp_valid;
    logic disp_ready;
    logic [uiq_pkg::xlen-1:0] pc;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [uiq_pkg::tag_w-1:0] src1_tag;
    logic [uiq_pkg::xlen-1:0] src1_data;
    logic src1_rdy;
    logic [uiq_pkg::tag_w-1:0] src2_tag;
    logic [uiq_pkg::xlen-1:0] src2_data;
    logic src2_rdy;
    logic [uiq_pkg::xlen-1:0] imm;
    logic [uiq_pkg::tag_w-1:0] dest;
    logic [uiq_pkg::tag_w-1:0] rob;
    logic [uiq_pkg::num_wb-1:0] wb_valid;
    logic [uiq_pkg::num_wb-1:0][uiq_pkg::tag_w-1:0] wb_tag;
    logic [uiq_pkg::num_wb-1:0][uiq_pkg::xlen-1:0] wb_data;
    logic [uiq_pkg::num_units-1:0] issue_valid;
    logic [uiq_pkg::num_units-1:0] issue_ready;
    logic [uiq_pkg::num_units-1:0][uiq_pkg::xlen-1:0] issue_pc;
    uiq_pkg::op_t [uiq_pkg::num_units-1:0] issue_op;
    logic [uiq_pkg::num_units-1:0][uiq_pkg::xlen-1:0] issue_src1;
    logic [uiq_pkg::num_units-1:0][uiq_pkg::xlen-1:0] issue_src2;
    logic [uiq_pkg::num_units-1:0][uiq_pkg::xlen-1:0] issue_imm;
    logic [uiq_pkg::num_units-1:0][uiq_pkg::tag_w-1:0] issue_dest;
    logic [uiq_pkg::num_units-1:0][uiq_pkg::tag_w-1:0] issue_rob;

    // reference model, one record per rob number.
    bit outstanding [n_rob];
    uiq_pkg::op_t m_op [n_rob];
    uiq_pkg::unit_t m_unit [n_rob];
    logic [uiq_pkg::xlen-1:0] m_pc [n_rob];
    logic [uiq_pkg::xlen-1:0] m_imm [n_rob];
    logic [uiq_pkg::tag_w-1:0] m_dest [n_rob];
    logic [uiq_pkg::xlen-1:0] m_src1 [n_rob];
    logic [uiq_pkg::xlen-1:0] m_src2 [n_rob];
    logic [uiq_pkg::tag_w-1:0] m_tag1 [n_rob];
    logic [uiq_pkg::tag_w-1:0] m_tag2 [n_rob];
    bit m_wait1 [n_rob];
    bit m_wait2 [n_rob];
    bit tag_pend [n_rob];
    bit rr_alu1;
    bit hold_on;
    bit held [uiq_pkg::num_units];
    logic [uiq_pkg::tag_w-1:0] held_rob [uiq_pkg::num_units];
    logic [uiq_pkg::xlen-1:0] held_src1 [uiq_pkg::num_units];
    int errors;
    int checks;
    int tests;
    int accepted;
    int issued;
    int rob_next;

    issue_queue_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(20 * n_total * 10);
        $display("watchdog expired after %0d time units", 20 * n_total * 10);
        $display("FAIL: see errors above");
        $finish;
    end

    task automatic check_op(input string name, input uiq_pkg::op_t got,
                            input uiq_pkg::op_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input logic [uiq_pkg::xlen-1:0] got,
                              input logic [uiq_pkg::xlen-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_unit(input int r, input int port, output bit ok);
        checks++;
        ok = outstanding[r];
        if (!ok) begin
            errors++;
            $display("rob %0d showed up on port %0d but no such instruction waits", r, port);
        end else if (int'(m_unit[r]) != port) begin
            errors++;
            $display("rob %0d issued on port %0d instead of unit %0d", r, port, m_unit[r]);
        end
    endtask

    function automatic uiq_pkg::op_t model_decode(logic [6:0] opc, logic [2:0] f3,
                                                  logic [6:0] f7);
        if (opc == 7'b0110111) begin
            return uiq_pkg::op_lui;
        end
        case ({opc, f3})
            {7'b0110011, 3'b000}: return (f7 == 7'h00) ? uiq_pkg::op_add : uiq_pkg::op_none;
            {7'b0110011, 3'b100}: return (f7 == 7'h00) ? uiq_pkg::op_xor : uiq_pkg::op_none;
            {7'b0010011, 3'b000}: return uiq_pkg::op_addi;
            {7'b0010011, 3'b110}: return uiq_pkg::op_ori;
            {7'b0010011, 3'b101}: return (f7 == 7'h20) ? uiq_pkg::op_srai : uiq_pkg::op_none;
            {7'b0000011, 3'b000}: return uiq_pkg::op_lb;
            {7'b0000011, 3'b010}: return uiq_pkg::op_lw;
            {7'b0100011, 3'b000}: return uiq_pkg::op_sb;
            {7'b0100011, 3'b010}: return uiq_pkg::op_sw;
            default: return uiq_pkg::op_none;
        endcase
    endfunction

    function automatic int occupancy();
        int cnt;
        cnt = 0;
        for (int i = 0; i < n_rob; i++) begin
            cnt += int'(outstanding[i]);
        end
        return cnt;
    endfunction

    // k 9 and up are encodings outside the subset.
    task automatic pick_encoding(input bit mixed);
        int k;
        k = $urandom % (mixed ? 12 : 9);
        funct3 = 3'($urandom);
        funct7 = 7'($urandom);
        case (k)
            0: begin
                opcode = 7'b0110011;
                funct3 = funct3[0] ? 3'b100 : 3'b000;
                funct7 = 7'h00;
            end
            1, 2: begin
                opcode = 7'b0010011;
                funct3 = funct3[0] ? 3'b110 : 3'b000;
            end
            3: begin
                opcode = 7'b0010011;
                funct3 = 3'b101;
                funct7 = 7'h20;
            end
            4: opcode = 7'b0110111;
            5, 6, 7, 8: begin
                opcode = funct3[1] ? 7'b0000011 : 7'b0100011;
                funct3 = funct3[0] ? 3'b010 : 3'b000;
            end
            9: begin
                opcode = 7'b0010011;
                funct3 = 3'b101;
                funct7 = 7'h00;
            end
            10: begin
                opcode = 7'b0110011;
                funct7 = 7'h20;
            end
            default: opcode = 7'($urandom);
        endcase
    endtask

    task automatic pick_source(input bit may_wait, output logic rdy,
                               output logic [uiq_pkg::tag_w-1:0] tag,
                               output logic [uiq_pkg::xlen-1:0] data);
        int b;
        b = $urandom % uiq_pkg::num_wb;
        data = $urandom;
        tag = uiq_pkg::tag_w'($urandom);
        rdy = !may_wait || ($urandom % 2 == 0);
        if (!rdy && wb_valid[b] && ($urandom % 3 == 0)) begin
            // wakes up in the same cycle as its dispatch.
            tag = wb_tag[b];
        end else if (!rdy) begin
            tag_pend[tag] = 1'b1;
        end
    endtask

    task automatic pick_broadcasts(input bit all);
        int start;
        int t;
        for (int b = 0; b < uiq_pkg::num_wb; b++) begin
            wb_valid[b] = 1'b0;
            wb_data[b] = $urandom;
            wb_tag[b] = uiq_pkg::tag_w'($urandom);
            if (all || ($urandom % 3 == 0)) begin
                start = $urandom % n_rob;
                for (int i = 0; i < n_rob; i++) begin
                    t = (start + i) % n_rob;
                    if (!wb_valid[b] && tag_pend[t]) begin
                        wb_valid[b] = 1'b1;
                        wb_tag[b] = uiq_pkg::tag_w'(t);
                        tag_pend[t] = 1'b0;
                    end
                end
            end
        end
    endtask

    task automatic drive_dispatch(input bit mixed, input bit valid);
        disp_valid = valid;
        pc = $urandom;
        imm = $urandom;
        dest = uiq_pkg::tag_w'($urandom);
        pick_encoding(mixed);
        pick_source(mixed, src1_rdy, src1_tag, src1_data);
        pick_source(mixed, src2_rdy, src2_tag, src2_data);
        while (outstanding[rob_next]) begin
            rob_next = (rob_next + 1) % n_rob;
        end
        rob = uiq_pkg::tag_w'(rob_next);
        rob_next = (rob_next + 1) % n_rob;
    endtask

    // model update for the coming edge: issue, then dispatch, then wakeup.
    task automatic observe();
        uiq_pkg::op_t op;
        int r;
        bit ok;
        bit zero1;
        bit zero2;
        check_flag("disp_ready", disp_ready, occupancy() < uiq_pkg::depth);
        for (int n = 0; n < uiq_pkg::num_units; n++) begin
            if (hold_on && held[n]) begin
                check_flag("issue_valid", issue_valid[n], 1'b1);
                check_data("issue_rob", 32'(issue_rob[n]), 32'(held_rob[n]));
                check_data("issue_src1", issue_src1[n], held_src1[n]);
            end
            held[n] = issue_valid[n] && !issue_ready[n];
            held_rob[n] = issue_rob[n];
            held_src1[n] = issue_src1[n];
            if (issue_valid[n]) begin
                r = int'(issue_rob[n]);
                check_unit(r, n, ok);
                if (ok) begin
                    if (m_wait1[r] || m_wait2[r]) begin
                        errors++;
                        $display("rob %0d issued on port %0d before its sources were ready",
                                 r, n);
                    end
                    check_op("issue_op", issue_op[n], m_op[r]);
                    check_data("issue_src1", issue_src1[n], m_src1[r]);
                    check_data("issue_src2", issue_src2[n], m_src2[r]);
                    check_data("issue_pc", issue_pc[n], m_pc[r]);
                    check_data("issue_imm", issue_imm[n], m_imm[r]);
                    check_data("issue_dest", 32'(issue_dest[n]), 32'(m_dest[r]));
                    if (issue_ready[n]) begin
                        outstanding[r] = 1'b0;
                        issued++;
                    end
                end
            end
        end
        op = model_decode(opcode, funct3, funct7);
        if (disp_valid && disp_ready && op != uiq_pkg::op_none) begin
            r = int'(rob);
            outstanding[r] = 1'b1;
            accepted++;
            m_op[r] = op;
            m_pc[r] = pc;
            m_imm[r] = imm;
            m_dest[r] = dest;
            if (op inside {uiq_pkg::op_lb, uiq_pkg::op_lw, uiq_pkg::op_sb, uiq_pkg::op_sw}) begin
                m_unit[r] = uiq_pkg::unit_mem;
            end else begin
                m_unit[r] = rr_alu1 ? uiq_pkg::unit_alu1 : uiq_pkg::unit_alu0;
                rr_alu1 = !rr_alu1;
            end
            zero1 = (op == uiq_pkg::op_lui);
            zero2 = op inside {uiq_pkg::op_addi, uiq_pkg::op_ori, uiq_pkg::op_srai,
                               uiq_pkg::op_lui, uiq_pkg::op_lb, uiq_pkg::op_lw};
            m_wait1[r] = !zero1 && !src1_rdy;
            m_wait2[r] = !zero2 && !src2_rdy;
            m_src1[r] = zero1 ? '0 : src1_data;
            m_src2[r] = zero2 ? '0 : src2_data;
            m_tag1[r] = src1_tag;
            m_tag2[r] = src2_tag;
        end
        for (int b = 0; b < uiq_pkg::num_wb; b++) begin
            for (int i = 0; i < n_rob; i++) begin
                if (wb_valid[b] && outstanding[i] && m_wait1[i] && m_tag1[i] == wb_tag[b]) begin
                    m_wait1[i] = 1'b0;
                    m_src1[i] = wb_data[b];
                end
                if (wb_valid[b] && outstanding[i] && m_wait2[i] && m_tag2[i] == wb_tag[b]) begin
                    m_wait2[i] = 1'b0;
                    m_src2[i] = wb_data[b];
                end
            end
        end
    endtask

    // entered 1 after an edge, samples 1 before the next one.
    task automatic step();
        #8;
        observe();
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        int cycles;
        disp_valid = 1'b0;
        issue_ready = '1;
        cycles = 0;
        while (occupancy() != 0 && cycles < drain_limit) begin
            pick_broadcasts(1'b1);
            step();
            cycles++;
        end
        if (occupancy() != 0) begin
            errors++;
            $display("%0d accepted instructions never issued", occupancy());
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_start);
    endtask

    initial begin
        int err_start;
        int fill_start;
        int rel;
        void'($urandom(32'hc14d8b53));
        rstn = 1'b0;
        disp_valid = 1'b0;
        {pc, imm, src1_data, src2_data} = '0;
        {opcode, funct3, funct7} = '0;
        {src1_tag, src2_tag, dest, rob, src1_rdy, src2_rdy} = '0;
        {wb_valid, wb_tag, wb_data} = '0;
        issue_ready = '0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;

        err_start = errors;
        check_flag("disp_ready", disp_ready, 1'b1);
        check_data("issue_valid", 32'(issue_valid), 32'h0);
        end_test("reset state", err_start);

        err_start = errors;
        for (int c = 0; c < n_random; c++) begin
            pick_broadcasts(1'b0);
            drive_dispatch(1'b1, ($urandom % 4) != 0);
            issue_ready = 3'($urandom);
            step();
        end
        drain();
        end_test("random dispatch and wakeup", err_start);

        // all ports stalled, queue fills from empty.
        err_start = errors;
        wb_valid = '0;
        issue_ready = '0;
        hold_on = 1'b1;
        fill_start = accepted;
        for (int c = 0; c < uiq_pkg::depth + 2; c++) begin
            drive_dispatch(1'b0, 1'b1);
            step();
        end
        check_data("accepted", 32'(accepted - fill_start), 32'(uiq_pkg::depth));
        check_flag("disp_ready", disp_ready, 1'b0);
        rel = 0;
        for (int n = uiq_pkg::num_units - 1; n >= 0; n--) begin
            if (issue_valid[n]) begin
                rel = n;
            end
        end
        disp_valid = 1'b0;
        issue_ready = 3'(1 << rel);
        step();
        issue_ready = '0;
        check_flag("disp_ready", disp_ready, 1'b1);
        step();
        hold_on = 1'b0;
        drain();
        end_test("back-pressure fill", err_start);

        $display("tests %0d, accepted %0d, issued %0d, checks %0d, errors %0d",
                 tests, accepted, issued, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: hdl/issue_queue_top.sv
module issue_queue_top (
    input  logic                                               clk,
    input  logic                                               rstn,
    input  logic                                               disp_valid,
    output logic                                               disp_ready,
    input  logic [uiq_pkg::xlen-1:0]                           pc,
    input  logic [6:0]                                         opcode,
    input  logic [2:0]                                         funct3,
    input  logic [6:0]                                         funct7,
    input  logic [uiq_pkg::tag_w-1:0]                          src1_tag,
    input  logic [uiq_pkg::xlen-1:0]                           src1_data,
    input  logic                                               src1_rdy,
    input  logic [uiq_pkg::tag_w-1:0]                          src2_tag,
    input  logic [uiq_pkg::xlen-1:0]                           src2_data,
    input  logic                                               src2_rdy,
    input  logic [uiq_pkg::xlen-1:0]                           imm,
    input  logic [uiq_pkg::tag_w-1:0]                          dest,
    input  logic [uiq_pkg::tag_w-1:0]                          rob,
    input  logic [uiq_pkg::num_wb-1:0]                         wb_valid,
    input  logic [uiq_pkg::num_wb-1:0][uiq_pkg::tag_w-1:0]     wb_tag,
    input  logic [uiq_pkg::num_wb-1:0][uiq_pkg::xlen-1:0]      wb_data,
    output logic [uiq_pkg::num_units-1:0]                      issue_valid,
    input  logic [uiq_pkg::num_units-1:0]                      issue_ready,
    output logic [uiq_pkg::num_units-1:0][uiq_pkg::xlen-1:0]   issue_pc,
    output uiq_pkg::op_t [uiq_pkg::num_units-1:0]              issue_op,
    output logic [uiq_pkg::num_units-1:0][uiq_pkg::xlen-1:0]   issue_src1,
    output logic [uiq_pkg::num_units-1:0][uiq_pkg::xlen-1:0]   issue_src2,
    output logic [uiq_pkg::num_units-1:0][uiq_pkg::xlen-1:0]   issue_imm,
    output logic [uiq_pkg::num_units-1:0][uiq_pkg::tag_w-1:0]  issue_dest,
    output logic [uiq_pkg::num_units-1:0][uiq_pkg::tag_w-1:0]  issue_rob
);

    uiq_pkg::op_t dec_op;
    logic dec_is_mem;
    logic dec_zero_src1;
    logic dec_zero_src2;
    logic [uiq_pkg::depth-1:0] entry_valid;
    uiq_pkg::entry_t [uiq_pkg::depth-1:0] entries;
    logic [uiq_pkg::num_units-1:0] sel_req;
    logic [uiq_pkg::num_units-1:0][uiq_pkg::idx_w-1:0] sel_idx;

    alloc_if alloc_bus ();
    wakeup_if wb_bus ();

    // result buses enter as plain ports.
    assign wb_bus.valid = wb_valid;
    assign wb_bus.tag = wb_tag;
    assign wb_bus.data = wb_data;

    op_decoder u_dec (
        .opcode(opcode), .funct3(funct3), .funct7(funct7), .op(dec_op),
        .is_mem(dec_is_mem), .zero_src1(dec_zero_src1), .zero_src2(dec_zero_src2)
    );

    issue_ctrl u_ctrl (
        .clk(clk), .rstn(rstn), .disp_valid(disp_valid), .disp_ready(disp_ready),
        .dec_op(dec_op), .dec_is_mem(dec_is_mem),
        .dec_zero_src1(dec_zero_src1), .dec_zero_src2(dec_zero_src2),
        .pc(pc), .src1_tag(src1_tag), .src1_data(src1_data), .src1_rdy(src1_rdy),
        .src2_tag(src2_tag), .src2_data(src2_data), .src2_rdy(src2_rdy),
        .imm(imm), .dest(dest), .rob(rob), .entry_valid(entry_valid),
        .sel_req(sel_req), .sel_idx(sel_idx), .issue_ready(issue_ready),
        .alloc(alloc_bus)
    );

    issue_entries u_entries (
        .clk(clk), .rstn(rstn), .alloc(alloc_bus), .wb(wb_bus),
        .entry_valid(entry_valid), .entries(entries)
    );

    issue_select u_sel (
        .entry_valid(entry_valid), .entries(entries), .sel_req(sel_req),
        .sel_idx(sel_idx), .issue_valid(issue_valid), .issue_pc(issue_pc),
        .issue_op(issue_op), .issue_src1(issue_src1), .issue_src2(issue_src2),
        .issue_imm(issue_imm), .issue_dest(issue_dest), .issue_rob(issue_rob)
    );

endmodule

// File: hdl/issue_select.sv
module issue_select (
    input  logic [uiq_pkg::depth-1:0]                          entry_valid,
    input  uiq_pkg::entry_t [uiq_pkg::depth-1:0]               entries,
    output logic [uiq_pkg::num_units-1:0]                      sel_req,
    output logic [uiq_pkg::num_units-1:0][uiq_pkg::idx_w-1:0]  sel_idx,
    output logic [uiq_pkg::num_units-1:0]                      issue_valid,
    output logic [uiq_pkg::num_units-1:0][uiq_pkg::xlen-1:0]   issue_pc,
    output uiq_pkg::op_t [uiq_pkg::num_units-1:0]              issue_op,
    output logic [uiq_pkg::num_units-1:0][uiq_pkg::xlen-1:0]   issue_src1,
    output logic [uiq_pkg::num_units-1:0][uiq_pkg::xlen-1:0]   issue_src2,
    output logic [uiq_pkg::num_units-1:0][uiq_pkg::xlen-1:0]   issue_imm,
    output logic [uiq_pkg::num_units-1:0][uiq_pkg::tag_w-1:0]  issue_dest,
    output logic [uiq_pkg::num_units-1:0][uiq_pkg::tag_w-1:0]  issue_rob
);

    // lowest ready entry per unit.
    always_comb begin
        sel_req = '0;
        sel_idx = '0;
        for (int n = 0; n < uiq_pkg::num_units; n++) begin
            for (int i = 0; i < uiq_pkg::depth; i++) begin
                if (!sel_req[n] && entry_valid[i] && (int'(entries[i].unit) == n) &&
                    entries[i].src1_rdy && entries[i].src2_rdy) begin
                    sel_req[n] = 1'b1;
                    sel_idx[n] = uiq_pkg::idx_w'(i);
                end
            end
        end
    end

    assign issue_valid = sel_req;

    // port payload follows the chosen slot.
    always_comb begin
        for (int n = 0; n < uiq_pkg::num_units; n++) begin
            issue_pc[n] = entries[sel_idx[n]].pc;
            issue_op[n] = entries[sel_idx[n]].op;
            issue_src1[n] = entries[sel_idx[n]].src1_data;
            issue_src2[n] = entries[sel_idx[n]].src2_data;
            issue_imm[n] = entries[sel_idx[n]].imm;
            issue_dest[n] = entries[sel_idx[n]].dest;
            issue_rob[n] = entries[sel_idx[n]].rob;
        end
    end

endmodule

// File: hdl/issue_entries.sv
module issue_entries (
    input  logic                                   clk,
    input  logic                                   rstn,
    alloc_if.storage                               alloc,
    wakeup_if.sink                                 wb,
    output logic [uiq_pkg::depth-1:0]              entry_valid,
    output uiq_pkg::entry_t [uiq_pkg::depth-1:0]   entries
);

    logic [uiq_pkg::depth-1:0] valid_q;
    logic [uiq_pkg::depth-1:0] valid_nxt;
    uiq_pkg::entry_t [uiq_pkg::depth-1:0] entries_q;
    uiq_pkg::entry_t [uiq_pkg::depth-1:0] entries_nxt;

    // valid bits.
    always_comb begin
        valid_nxt = valid_q & ~alloc.release_mask;
        if (alloc.we) begin
            valid_nxt[alloc.idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_nxt;
        end
    end

    // contents, the write comes first so wakeup also covers it.
    always_comb begin
        for (int i = 0; i < uiq_pkg::depth; i++) begin
            entries_nxt[i] = entries_q[i];
            if (alloc.we && (alloc.idx == uiq_pkg::idx_w'(i))) begin
                entries_nxt[i] = alloc.entry;
            end
            for (int b = 0; b < uiq_pkg::num_wb; b++) begin
                // only a waiting source captures.
                if (wb.valid[b] && !entries_nxt[i].src1_rdy &&
                    (entries_nxt[i].src1_tag == wb.tag[b])) begin
                    entries_nxt[i].src1_data = wb.data[b];
                    entries_nxt[i].src1_rdy = 1'b1;
                end
                if (wb.valid[b] && !entries_nxt[i].src2_rdy &&
                    (entries_nxt[i].src2_tag == wb.tag[b])) begin
                    entries_nxt[i].src2_data = wb.data[b];
                    entries_nxt[i].src2_rdy = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        entries_q <= entries_nxt;
    end

    assign entry_valid = valid_q;
    assign entries = entries_q;

endmodule

// File: hdl/issue_ctrl.sv
module issue_ctrl (
    input  logic                                             clk,
    input  logic                                             rstn,
    input  logic                                             disp_valid,
    output logic                                             disp_ready,
    input  uiq_pkg::op_t                                     dec_op,
    input  logic                                             dec_is_mem,
    input  logic                                             dec_zero_src1,
    input  logic                                             dec_zero_src2,
    input  logic [uiq_pkg::xlen-1:0]                         pc,
    input  logic [uiq_pkg::tag_w-1:0]                        src1_tag,
    input  logic [uiq_pkg::xlen-1:0]                         src1_data,
    input  logic                                             src1_rdy,
    input  logic [uiq_pkg::tag_w-1:0]                        src2_tag,
    input  logic [uiq_pkg::xlen-1:0]                         src2_data,
    input  logic                                             src2_rdy,
    input  logic [uiq_pkg::xlen-1:0]                         imm,
    input  logic [uiq_pkg::tag_w-1:0]                        dest,
    input  logic [uiq_pkg::tag_w-1:0]                        rob,
    input  logic [uiq_pkg::depth-1:0]                        entry_valid,
    input  logic [uiq_pkg::num_units-1:0]                    sel_req,
    input  logic [uiq_pkg::num_units-1:0][uiq_pkg::idx_w-1:0] sel_idx,
    input  logic [uiq_pkg::num_units-1:0]                    issue_ready,
    alloc_if.driver                                          alloc
);

    logic free_found;
    logic [uiq_pkg::idx_w-1:0] free_idx;
    logic alloc_we;
    logic rr_alu1;
    uiq_pkg::entry_t new_entry;

    // lowest free slot.
    always_comb begin
        free_found = 1'b0;
        free_idx = '0;
        for (int i = 0; i < uiq_pkg::depth; i++) begin
            if (!entry_valid[i] && !free_found) begin
                free_found = 1'b1;
                free_idx = uiq_pkg::idx_w'(i);
            end
        end
    end

    assign disp_ready = free_found;

    // unsupported encodings are taken but dropped here.
    assign alloc_we = disp_valid && disp_ready && (dec_op != uiq_pkg::op_none);

    // alu round robin, moves only on an accepted alu op.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rr_alu1 <= 1'b0;
        end else if (alloc_we && !dec_is_mem) begin
            rr_alu1 <= ~rr_alu1;
        end
    end

    always_comb begin
        new_entry.pc = pc;
        new_entry.op = dec_op;
        if (dec_is_mem) begin
            new_entry.unit = uiq_pkg::unit_mem;
        end else begin
            new_entry.unit = rr_alu1 ? uiq_pkg::unit_alu1 : uiq_pkg::unit_alu0;
        end
        new_entry.src1_tag = src1_tag;
        new_entry.src1_data = dec_zero_src1 ? '0 : src1_data;
        new_entry.src1_rdy = dec_zero_src1 | src1_rdy;
        new_entry.src2_tag = src2_tag;
        new_entry.src2_data = dec_zero_src2 ? '0 : src2_data;
        new_entry.src2_rdy = dec_zero_src2 | src2_rdy;
        new_entry.imm = imm;
        new_entry.dest = dest;
        new_entry.rob = rob;
    end

    // an entry leaves at the edge where its port handshakes.
    always_comb begin
        alloc.release_mask = '0;
        for (int n = 0; n < uiq_pkg::num_units; n++) begin
            if (sel_req[n] && issue_ready[n]) begin
                alloc.release_mask[sel_idx[n]] = 1'b1;
            end
        end
    end

    assign alloc.we = alloc_we;
    assign alloc.idx = free_idx;
    assign alloc.entry = new_entry;

endmodule

// File: hdl/op_decoder.sv
module op_decoder (
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    output uiq_pkg::op_t    op,
    output logic            is_mem,
    output logic            zero_src1,
    output logic            zero_src2
);

    always_comb begin
        op = uiq_pkg::op_none;
        case (opcode)
            uiq_pkg::opc_op: begin
                // r-type needs the exact base funct7.
                if (funct7 == uiq_pkg::f7_base) begin
                    if (funct3 == 3'b000) begin
                        op = uiq_pkg::op_add;
                    end else if (funct3 == 3'b100) begin
                        op = uiq_pkg::op_xor;
                    end
                end
            end
            uiq_pkg::opc_op_imm: begin
                if (funct3 == 3'b000) begin
                    op = uiq_pkg::op_addi;
                end else if (funct3 == 3'b110) begin
                    op = uiq_pkg::op_ori;
                end else if (funct3 == 3'b101 && funct7 == uiq_pkg::f7_alt) begin
                    // srli shares funct3, only the arithmetic form is kept.
                    op = uiq_pkg::op_srai;
                end
            end
            uiq_pkg::opc_lui: op = uiq_pkg::op_lui;
            uiq_pkg::opc_load: begin
                if (funct3 == 3'b000) begin
                    op = uiq_pkg::op_lb;
                end else if (funct3 == 3'b010) begin
                    op = uiq_pkg::op_lw;
                end
            end
            uiq_pkg::opc_store: begin
                if (funct3 == 3'b000) begin
                    op = uiq_pkg::op_sb;
                end else if (funct3 == 3'b010) begin
                    op = uiq_pkg::op_sw;
                end
            end
            default: op = uiq_pkg::op_none;
        endcase
    end

    assign is_mem = (op == uiq_pkg::op_lb) || (op == uiq_pkg::op_lw) ||
                    (op == uiq_pkg::op_sb) || (op == uiq_pkg::op_sw);

    // lui has no register sources at all.
    assign zero_src1 = (op == uiq_pkg::op_lui);

    // immediate forms and loads take no second register.
    assign zero_src2 = (op == uiq_pkg::op_addi) || (op == uiq_pkg::op_ori) ||
                       (op == uiq_pkg::op_srai) || (op == uiq_pkg::op_lui) ||
                       (op == uiq_pkg::op_lb) || (op == uiq_pkg::op_lw);

endmodule

// File: hdl/uiq_ifs.sv
// allocation and release traffic from control to entry storage.
interface alloc_if;

    logic we;
    logic [uiq_pkg::idx_w-1:0] idx;
    uiq_pkg::entry_t entry;
    logic [uiq_pkg::depth-1:0] release_mask;

    modport driver (
        output we,
        output idx,
        output entry,
        output release_mask
    );

    modport storage (
        input we,
        input idx,
        input entry,
        input release_mask
    );

endinterface

// result bus broadcasts, one lane per bus.
interface wakeup_if;

    logic [uiq_pkg::num_wb-1:0] valid;
    logic [uiq_pkg::num_wb-1:0][uiq_pkg::tag_w-1:0] tag;
    logic [uiq_pkg::num_wb-1:0][uiq_pkg::xlen-1:0] data;

    // no handshake, a lane counts whenever valid is high.
    modport sink (
        input valid,
        input tag,
        input data
    );

endinterface

// File: hdl/uiq_pkg.sv
package uiq_pkg;

    // datapath and tag widths.
    localparam int xlen = 32;
    localparam int tag_w = 6;

    // queue geometry.
    localparam int depth = 16;
    localparam int idx_w = 4;

    // issue ports and result buses.
    localparam int num_units = 3;
    localparam int num_wb = 3;

    // rv32i major opcodes in the supported subset.
    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;

    // funct7 values for the base and alternate forms.
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt = 7'b0100000;

    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_add,
        op_addi,
        op_lui,
        op_ori,
        op_xor,
        op_srai,
        op_lb,
        op_lw,
        op_sb,
        op_sw
    } op_t;

    typedef enum logic [1:0] {
        unit_alu0 = 2'd0,
        unit_alu1 = 2'd1,
        unit_mem = 2'd2
    } unit_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        op_t op;
        unit_t unit;
        logic [tag_w-1:0] src1_tag;
        logic [xlen-1:0] src1_data;
        logic src1_rdy;
        logic [tag_w-1:0] src2_tag;
        logic [xlen-1:0] src2_data;
        logic src2_rdy;
        logic [xlen-1:0] imm;
        logic [tag_w-1:0] dest;
        logic [tag_w-1:0] rob;
    } entry_t;

endpackage
